/* src/reg_map_pkg.sv */
package reg_map_pkg;

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 16;
    localparam int THRE_W   = 16;
    localparam int DAC_W    = 12;
    localparam int BYPASS_W = 3;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [THRE_W-1:0] thre_t;
    typedef logic [DAC_W-1:0]  dac_word_t;

    // index of each writable register, grouped by bank
    typedef enum logic [4:0] {
        IDX_NONE,
        IDX_FIRST_REG, IDX_ADC_OFFSET, IDX_PMT_HV, IDX_BST_VCC_EN, IDX_PMT_TEST_EN,
        IDX_DEFECT_EN, IDX_PRE_ACC_CURR, IDX_ACTU_ACC_CURR, IDX_ACTU_ACC_CACHE,
        IDX_PARTICLE_BYPASS, IDX_FIRST_TRACK,
        IDX_RECOVER_FACTOR, IDX_CALI_MODE, IDX_CALI_LOW, IDX_CALI_HIGH,
        IDX_AOM_DELAY, IDX_AOM_HOLD
    } reg_idx_e;

    typedef enum logic [2:0] {
        GRP_NONE, GRP_ANALOG, GRP_DEFECT, GRP_CALI, GRP_STATUS
    } group_e;

    //////////////////////////////
    // byte addresses
    localparam addr_t ADDR_FIRST_REG       = 16'h000C;
    localparam addr_t ADDR_DEFECT_EN       = 16'h0014;
    localparam addr_t ADDR_ADC_OFFSET      = 16'h0018;
    localparam addr_t ADDR_PMT_HV          = 16'h001C;
    localparam addr_t ADDR_BST_VCC_EN      = 16'h0020;
    localparam addr_t ADDR_PMT_TEST_EN     = 16'h0024;
    localparam addr_t ADDR_PRE_ACC_CURR    = 16'h0038;
    localparam addr_t ADDR_ACTU_ACC_CURR   = 16'h003C;
    localparam addr_t ADDR_ACTU_ACC_CACHE  = 16'h0040;
    localparam addr_t ADDR_PARTICLE_BYPASS = 16'h0044;
    localparam addr_t ADDR_FIRST_TRACK     = 16'h0048;
    localparam addr_t ADDR_RECOVER_FACTOR  = 16'h0050;
    localparam addr_t ADDR_CALI_MODE       = 16'h0054;
    localparam addr_t ADDR_CALI_LOW        = 16'h0058;
    localparam addr_t ADDR_CALI_HIGH       = 16'h005C;
    localparam addr_t ADDR_AOM_DELAY       = 16'h0068;
    localparam addr_t ADDR_AOM_HOLD        = 16'h006C;
    localparam addr_t ADDR_ACC_TRIG_NUM    = 16'h0078;
    // most significant version word sits at the lowest address
    localparam addr_t ADDR_VERSION_0       = 16'h1000;
    localparam addr_t ADDR_VERSION_1       = 16'h1004;
    localparam addr_t ADDR_VERSION_2       = 16'h1008;
    localparam addr_t ADDR_VERSION_3       = 16'h100C;
    localparam addr_t ADDR_VERSION_4       = 16'h1010;
    localparam addr_t ADDR_DBG_ACC_FLAG    = 16'h1100;
    localparam addr_t ADDR_PRE_WIDEN_CNT   = 16'h1104;
    localparam addr_t ADDR_CURR_WIDEN_CNT  = 16'h1108;
    localparam addr_t ADDR_CACHE_WIDEN_CNT = 16'h110C;

    //////////////////////////////
    // hardware reset values
    localparam data_t                RST_FIRST_REG       = '0;
    localparam data_t                RST_ADC_OFFSET      = '0;
    localparam data_t                RST_PMT_HV          = '0;
    localparam logic                 RST_BST_VCC_EN      = 1'b1;
    localparam logic                 RST_PMT_TEST_EN     = 1'b0;
    localparam logic                 RST_DEFECT_EN       = 1'b0;
    localparam thre_t                RST_PRE_ACC_CURR    = '0;
    localparam thre_t                RST_ACTU_ACC_CURR   = '0;
    localparam thre_t                RST_ACTU_ACC_CACHE  = '0;
    localparam logic [BYPASS_W-1:0]  RST_PARTICLE_BYPASS = '0;
    localparam logic                 RST_FIRST_TRACK     = 1'b1;
    localparam thre_t                RST_RECOVER_FACTOR  = 16'h0100;
    localparam logic                 RST_CALI_MODE       = 1'b0;
    // 800 ms and 200 ms at the 10 MHz calibration tick
    localparam data_t                RST_CALI_LOW        = 32'd8_000_000;
    localparam data_t                RST_CALI_HIGH       = 32'd2_000_000;
    localparam thre_t                RST_AOM_DELAY       = '0;
    localparam thre_t                RST_AOM_HOLD        = '0;

    localparam data_t               DEAD_WORD   = 32'h00DE_AD00;
    localparam logic [5*DATA_W-1:0] VERSION_STR = "PMTM_REG_MAP_v2.0   ";

endpackage

/* src/spi_reg_ctrl.sv */
`timescale 1ns/1ns

module spi_reg_ctrl
    import reg_map_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     wr_en_i,
    input  logic     rd_en_i,
    input  addr_t    addr_i,
    input  data_t    wr_data_i,
    // bank words for the current index
    input  data_t    analog_rd_i,
    input  data_t    defect_rd_i,
    input  data_t    cali_rd_i,
    input  data_t    acc_trigger_num_i,
    input  data_t    dbg_acc_flag_cnt_i,
    input  data_t    pre_widen_cnt_i,
    input  data_t    curr_widen_cnt_i,
    input  data_t    cache_widen_cnt_i,
    output logic     reg_wr_o,
    output reg_idx_e reg_idx_o,
    output data_t    wr_data_o,
    output logic     rd_vld_o,
    output data_t    rd_data_o
);

    reg_idx_e idx;
    group_e   grp;
    logic     status_hit;
    data_t    status_word;
    data_t    rd_word;

    //////////////////////////////
    // address decode
    always_comb begin
        case (addr_i)
            ADDR_FIRST_REG:       idx = IDX_FIRST_REG;
            ADDR_ADC_OFFSET:      idx = IDX_ADC_OFFSET;
            ADDR_PMT_HV:          idx = IDX_PMT_HV;
            ADDR_BST_VCC_EN:      idx = IDX_BST_VCC_EN;
            ADDR_PMT_TEST_EN:     idx = IDX_PMT_TEST_EN;
            ADDR_DEFECT_EN:       idx = IDX_DEFECT_EN;
            ADDR_PRE_ACC_CURR:    idx = IDX_PRE_ACC_CURR;
            ADDR_ACTU_ACC_CURR:   idx = IDX_ACTU_ACC_CURR;
            ADDR_ACTU_ACC_CACHE:  idx = IDX_ACTU_ACC_CACHE;
            ADDR_PARTICLE_BYPASS: idx = IDX_PARTICLE_BYPASS;
            ADDR_FIRST_TRACK:     idx = IDX_FIRST_TRACK;
            ADDR_RECOVER_FACTOR:  idx = IDX_RECOVER_FACTOR;
            ADDR_CALI_MODE:       idx = IDX_CALI_MODE;
            ADDR_CALI_LOW:        idx = IDX_CALI_LOW;
            ADDR_CALI_HIGH:       idx = IDX_CALI_HIGH;
            ADDR_AOM_DELAY:       idx = IDX_AOM_DELAY;
            ADDR_AOM_HOLD:        idx = IDX_AOM_HOLD;
            default:              idx = IDX_NONE;
        endcase
    end

    // version and counters are served here
    always_comb begin
        status_hit  = 1'b1;
        status_word = DEAD_WORD;
        case (addr_i)
            ADDR_VERSION_0:       status_word = VERSION_STR[4*DATA_W +: DATA_W];
            ADDR_VERSION_1:       status_word = VERSION_STR[3*DATA_W +: DATA_W];
            ADDR_VERSION_2:       status_word = VERSION_STR[2*DATA_W +: DATA_W];
            ADDR_VERSION_3:       status_word = VERSION_STR[1*DATA_W +: DATA_W];
            ADDR_VERSION_4:       status_word = VERSION_STR[0*DATA_W +: DATA_W];
            ADDR_ACC_TRIG_NUM:    status_word = acc_trigger_num_i;
            ADDR_DBG_ACC_FLAG:    status_word = dbg_acc_flag_cnt_i;
            ADDR_PRE_WIDEN_CNT:   status_word = pre_widen_cnt_i;
            ADDR_CURR_WIDEN_CNT:  status_word = curr_widen_cnt_i;
            ADDR_CACHE_WIDEN_CNT: status_word = cache_widen_cnt_i;
            default:              status_hit  = 1'b0;
        endcase
    end

    // owning bank of each index
    always_comb begin
        case (idx)
            IDX_FIRST_REG, IDX_ADC_OFFSET, IDX_PMT_HV, IDX_BST_VCC_EN, IDX_PMT_TEST_EN:
                grp = GRP_ANALOG;
            IDX_DEFECT_EN, IDX_PRE_ACC_CURR, IDX_ACTU_ACC_CURR, IDX_ACTU_ACC_CACHE,
            IDX_PARTICLE_BYPASS, IDX_FIRST_TRACK:
                grp = GRP_DEFECT;
            IDX_RECOVER_FACTOR, IDX_CALI_MODE, IDX_CALI_LOW, IDX_CALI_HIGH,
            IDX_AOM_DELAY, IDX_AOM_HOLD:
                grp = GRP_CALI;
            default:
                grp = status_hit ? GRP_STATUS : GRP_NONE;
        endcase
    end

    // bank registers take the write on the strobe edge
    assign reg_wr_o  = wr_en_i && (idx != IDX_NONE);
    assign reg_idx_o = idx;
    assign wr_data_o = wr_data_i;

    //////////////////////////////
    // read path
    always_comb begin
        case (grp)
            GRP_ANALOG: rd_word = analog_rd_i;
            GRP_DEFECT: rd_word = defect_rd_i;
            GRP_CALI:   rd_word = cali_rd_i;
            GRP_STATUS: rd_word = status_word;
            default:    rd_word = DEAD_WORD;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_vld_o  <= 1'b0;
            rd_data_o <= '0;
        end else begin
            rd_vld_o <= rd_en_i;
            if (rd_en_i) begin
                rd_data_o <= rd_word;
            end
        end
    end

    // one valid per read strobe, one cycle late
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_vld_o == $past(rd_en_i));

endmodule

/* src/analog_ctrl_regs.sv */
`timescale 1ns/1ns

module analog_ctrl_regs
    import reg_map_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      reg_wr_i,
    input  reg_idx_e  reg_idx_i,
    input  data_t     wr_data_i,
    output data_t     rd_word_o,
    output data_t     first_reg_o,
    output thre_t     adc_offset_o,
    output logic      adc_offset_en_o,
    output dac_word_t dac_data_o,
    output logic      dac_config_en_o,
    output logic      bst_vcc_en_o,
    output logic      pmt_test_en_o
);

    data_t adc_offset_q;
    data_t pmt_hv_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            first_reg_o   <= RST_FIRST_REG;
            adc_offset_q  <= RST_ADC_OFFSET;
            pmt_hv_q      <= RST_PMT_HV;
            bst_vcc_en_o  <= RST_BST_VCC_EN;
            pmt_test_en_o <= RST_PMT_TEST_EN;
        end else if (reg_wr_i) begin
            case (reg_idx_i)
                IDX_FIRST_REG:   first_reg_o   <= wr_data_i;
                IDX_ADC_OFFSET:  adc_offset_q  <= wr_data_i;
                IDX_PMT_HV:      pmt_hv_q      <= wr_data_i;
                IDX_BST_VCC_EN:  bst_vcc_en_o  <= wr_data_i[0];
                IDX_PMT_TEST_EN: pmt_test_en_o <= wr_data_i[0];
                default: ;
            endcase
        end
    end

    // load strobes for the offset ADC and the HV DAC
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            adc_offset_en_o <= 1'b0;
            dac_config_en_o <= 1'b0;
        end else begin
            adc_offset_en_o <= reg_wr_i && (reg_idx_i == IDX_ADC_OFFSET);
            dac_config_en_o <= reg_wr_i && (reg_idx_i == IDX_PMT_HV);
        end
    end

    assign adc_offset_o = adc_offset_q[THRE_W-1:0];
    assign dac_data_o   = pmt_hv_q[DAC_W-1:0];

    always_comb begin
        case (reg_idx_i)
            IDX_FIRST_REG:   rd_word_o = first_reg_o;
            IDX_ADC_OFFSET:  rd_word_o = adc_offset_q;
            IDX_PMT_HV:      rd_word_o = pmt_hv_q;
            IDX_BST_VCC_EN:  rd_word_o = data_t'(bst_vcc_en_o);
            IDX_PMT_TEST_EN: rd_word_o = data_t'(pmt_test_en_o);
            default:         rd_word_o = '0;
        endcase
    end

    // a load strobe lasts a single cycle
    property p_one_shot(logic pulse);
        @(posedge clk_i) disable iff (!rst_n_i)
            pulse |=> !pulse;
    endproperty

    assert property (p_one_shot(adc_offset_en_o));
    assert property (p_one_shot(dac_config_en_o));

endmodule

/* src/defect_thre_regs.sv */
`timescale 1ns/1ns

module defect_thre_regs
    import reg_map_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                reg_wr_i,
    input  reg_idx_e            reg_idx_i,
    input  data_t               wr_data_i,
    output data_t               rd_word_o,
    output logic                acc_defect_en_o,
    output thre_t               pre_acc_curr_thre_o,
    output thre_t               actu_acc_curr_thre_o,
    output thre_t               actu_acc_cache_thre_o,
    output logic [BYPASS_W-1:0] particle_acc_bypass_o,
    output logic                first_track_ctrl_o
);

    // fields keep the low bits of the written word
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_defect_en_o       <= RST_DEFECT_EN;
            pre_acc_curr_thre_o   <= RST_PRE_ACC_CURR;
            actu_acc_curr_thre_o  <= RST_ACTU_ACC_CURR;
            actu_acc_cache_thre_o <= RST_ACTU_ACC_CACHE;
            particle_acc_bypass_o <= RST_PARTICLE_BYPASS;
            first_track_ctrl_o    <= RST_FIRST_TRACK;
        end else if (reg_wr_i) begin
            case (reg_idx_i)
                IDX_DEFECT_EN:       acc_defect_en_o       <= wr_data_i[0];
                IDX_PRE_ACC_CURR:    pre_acc_curr_thre_o   <= wr_data_i[THRE_W-1:0];
                IDX_ACTU_ACC_CURR:   actu_acc_curr_thre_o  <= wr_data_i[THRE_W-1:0];
                IDX_ACTU_ACC_CACHE:  actu_acc_cache_thre_o <= wr_data_i[THRE_W-1:0];
                IDX_PARTICLE_BYPASS: particle_acc_bypass_o <= wr_data_i[BYPASS_W-1:0];
                IDX_FIRST_TRACK:     first_track_ctrl_o    <= wr_data_i[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_idx_i)
            IDX_DEFECT_EN:       rd_word_o = data_t'(acc_defect_en_o);
            IDX_PRE_ACC_CURR:    rd_word_o = data_t'(pre_acc_curr_thre_o);
            IDX_ACTU_ACC_CURR:   rd_word_o = data_t'(actu_acc_curr_thre_o);
            IDX_ACTU_ACC_CACHE:  rd_word_o = data_t'(actu_acc_cache_thre_o);
            IDX_PARTICLE_BYPASS: rd_word_o = data_t'(particle_acc_bypass_o);
            IDX_FIRST_TRACK:     rd_word_o = data_t'(first_track_ctrl_o);
            default:             rd_word_o = '0;
        endcase
    end

endmodule

/* src/acc_cali_regs.sv */
`timescale 1ns/1ns

module acc_cali_regs
    import reg_map_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     reg_wr_i,
    input  reg_idx_e reg_idx_i,
    input  data_t    wr_data_i,
    output data_t    rd_word_o,
    output thre_t    lp_recover_factor_o,
    output thre_t    aom_ctrl_delay_o,
    output thre_t    aom_ctrl_hold_o,
    output logic     acc_cali_mode_o,
    output data_t    acc_cali_low_o,
    output data_t    acc_cali_high_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lp_recover_factor_o <= RST_RECOVER_FACTOR;
            acc_cali_mode_o     <= RST_CALI_MODE;
            acc_cali_low_o      <= RST_CALI_LOW;
            acc_cali_high_o     <= RST_CALI_HIGH;
            aom_ctrl_delay_o    <= RST_AOM_DELAY;
            aom_ctrl_hold_o     <= RST_AOM_HOLD;
        end else if (reg_wr_i) begin
            case (reg_idx_i)
                IDX_RECOVER_FACTOR: lp_recover_factor_o <= wr_data_i[THRE_W-1:0];
                IDX_CALI_MODE:      acc_cali_mode_o     <= wr_data_i[0];
                IDX_CALI_LOW:       acc_cali_low_o      <= wr_data_i;
                IDX_CALI_HIGH:      acc_cali_high_o     <= wr_data_i;
                IDX_AOM_DELAY:      aom_ctrl_delay_o    <= wr_data_i[THRE_W-1:0];
                IDX_AOM_HOLD:       aom_ctrl_hold_o     <= wr_data_i[THRE_W-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_idx_i)
            IDX_RECOVER_FACTOR: rd_word_o = data_t'(lp_recover_factor_o);
            IDX_CALI_MODE:      rd_word_o = data_t'(acc_cali_mode_o);
            IDX_CALI_LOW:       rd_word_o = acc_cali_low_o;
            IDX_CALI_HIGH:      rd_word_o = acc_cali_high_o;
            IDX_AOM_DELAY:      rd_word_o = data_t'(aom_ctrl_delay_o);
            IDX_AOM_HOLD:       rd_word_o = data_t'(aom_ctrl_hold_o);
            default:            rd_word_o = '0;
        endcase
    end

    // low window leaves its nonzero reset value only through a host write
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (acc_cali_low_o == '0) && ($past(acc_cali_low_o) != '0)
            |-> $past(reg_wr_i && reg_idx_i == IDX_CALI_LOW));

endmodule

/* src/spi_reg_map.sv */
`timescale 1ns/1ns

module spi_reg_map
    import reg_map_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    // host bus
    input  logic                wr_en_i,
    input  logic                rd_en_i,
    input  addr_t               addr_i,
    input  data_t               wr_data_i,
    output logic                rd_vld_o,
    output data_t               rd_data_o,
    // status inputs
    input  data_t               acc_trigger_num_i,
    input  data_t               dbg_acc_flag_cnt_i,
    input  data_t               pre_widen_cnt_i,
    input  data_t               curr_widen_cnt_i,
    input  data_t               cache_widen_cnt_i,
    // analog control
    output data_t               first_reg_o,
    output thre_t               adc_offset_o,
    output logic                adc_offset_en_o,
    output dac_word_t           dac_data_o,
    output logic                dac_config_en_o,
    output logic                bst_vcc_en_o,
    output logic                pmt_test_en_o,
    // defect thresholds
    output logic                acc_defect_en_o,
    output thre_t               pre_acc_curr_thre_o,
    output thre_t               actu_acc_curr_thre_o,
    output thre_t               actu_acc_cache_thre_o,
    output logic [BYPASS_W-1:0] particle_acc_bypass_o,
    output logic                first_track_ctrl_o,
    // calibration and AOM timing
    output thre_t               lp_recover_factor_o,
    output thre_t               aom_ctrl_delay_o,
    output thre_t               aom_ctrl_hold_o,
    output logic                acc_cali_mode_o,
    output data_t               acc_cali_low_o,
    output data_t               acc_cali_high_o
);

    logic     reg_wr;
    reg_idx_e reg_idx;
    data_t    bank_wr_data;
    data_t    analog_rd;
    data_t    defect_rd;
    data_t    cali_rd;

    spi_reg_ctrl u_ctrl (
        .*,
        .analog_rd_i (analog_rd),
        .defect_rd_i (defect_rd),
        .cali_rd_i   (cali_rd),
        .reg_wr_o    (reg_wr),
        .reg_idx_o   (reg_idx),
        .wr_data_o   (bank_wr_data)
    );

    analog_ctrl_regs u_analog (
        .*,
        .reg_wr_i  (reg_wr),
        .reg_idx_i (reg_idx),
        .wr_data_i (bank_wr_data),
        .rd_word_o (analog_rd)
    );

    defect_thre_regs u_defect (
        .*,
        .reg_wr_i  (reg_wr),
        .reg_idx_i (reg_idx),
        .wr_data_i (bank_wr_data),
        .rd_word_o (defect_rd)
    );

    acc_cali_regs u_cali (
        .*,
        .reg_wr_i  (reg_wr),
        .reg_idx_i (reg_idx),
        .wr_data_i (bank_wr_data),
        .rd_word_o (cali_rd)
    );

endmodule

/* include/reg_map_model.svh */
`ifndef REG_MAP_MODEL_SVH
`define REG_MAP_MODEL_SVH

// expected register contents by byte address
data_t stored [addr_t];

// bits a writable register keeps, zero for read-only and unmapped
function automatic data_t keep_mask(addr_t addr);
    case (addr)
        ADDR_FIRST_REG, ADDR_ADC_OFFSET, ADDR_PMT_HV, ADDR_CALI_LOW, ADDR_CALI_HIGH:
            return '1;
        ADDR_PRE_ACC_CURR, ADDR_ACTU_ACC_CURR, ADDR_ACTU_ACC_CACHE,
        ADDR_RECOVER_FACTOR, ADDR_AOM_DELAY, ADDR_AOM_HOLD:
            return data_t'({THRE_W{1'b1}});
        ADDR_PARTICLE_BYPASS:
            return data_t'({BYPASS_W{1'b1}});
        ADDR_BST_VCC_EN, ADDR_PMT_TEST_EN, ADDR_DEFECT_EN, ADDR_FIRST_TRACK,
        ADDR_CALI_MODE:
            return data_t'(1);
        default:
            return '0;
    endcase
endfunction

// only these registers come out of reset nonzero
function automatic data_t reset_value(addr_t addr);
    case (addr)
        ADDR_BST_VCC_EN:     return 32'd1;
        ADDR_FIRST_TRACK:    return 32'd1;
        ADDR_RECOVER_FACTOR: return 32'h0000_0100;
        ADDR_CALI_LOW:       return 32'd8_000_000;
        ADDR_CALI_HIGH:      return 32'd2_000_000;
        default:             return '0;
    endcase
endfunction

function automatic void clear_model();
    stored.delete();
endfunction

function automatic void apply_write(addr_t addr, data_t data);
    if (keep_mask(addr) != '0) begin
        stored[addr] = data & keep_mask(addr);
    end
endfunction

// cnt holds the trigger number then the four debug counters
function automatic data_t expected_read(addr_t addr);
    int slot;
    case (addr)
        ADDR_VERSION_0, ADDR_VERSION_1, ADDR_VERSION_2, ADDR_VERSION_3,
        ADDR_VERSION_4: begin
            // lowest address carries the leading four characters
            slot = (addr - ADDR_VERSION_0) >> 2;
            return data_t'(VERSION_STR >> (DATA_W * (4 - slot)));
        end
        ADDR_ACC_TRIG_NUM:    return cnt[0];
        ADDR_DBG_ACC_FLAG:    return cnt[1];
        ADDR_PRE_WIDEN_CNT:   return cnt[2];
        ADDR_CURR_WIDEN_CNT:  return cnt[3];
        ADDR_CACHE_WIDEN_CNT: return cnt[4];
        default: ;
    endcase
    if (keep_mask(addr) == '0) begin
        return DEAD_WORD;
    end
    return stored.exists(addr) ? stored[addr] : reset_value(addr);
endfunction

`endif

/* tests/tb_spi_reg_map.sv */
`timescale 1ns/1ns

module tb_spi_reg_map
    import reg_map_pkg::*;
();

    logic                clk_i;
    logic                rst_n_i;
    logic                wr_en_i;
    logic                rd_en_i;
    addr_t               addr_i;
    data_t               wr_data_i;
    logic                rd_vld_o;
    data_t               rd_data_o;
    data_t               cnt [5];
    data_t               first_reg_o;
    thre_t               adc_offset_o;
    logic                adc_offset_en_o;
    dac_word_t           dac_data_o;
    logic                dac_config_en_o;
    logic                bst_vcc_en_o;
    logic                pmt_test_en_o;
    logic                acc_defect_en_o;
    thre_t               pre_acc_curr_thre_o;
    thre_t               actu_acc_curr_thre_o;
    thre_t               actu_acc_cache_thre_o;
    logic [BYPASS_W-1:0] particle_acc_bypass_o;
    logic                first_track_ctrl_o;
    thre_t               lp_recover_factor_o;
    thre_t               aom_ctrl_delay_o;
    thre_t               aom_ctrl_hold_o;
    logic                acc_cali_mode_o;
    data_t               acc_cali_low_o;
    data_t               acc_cali_high_o;

`include "reg_map_model.svh"

    // writable registers, then version words, then counters
    addr_t map_addrs [27] = '{
        ADDR_FIRST_REG, ADDR_ADC_OFFSET, ADDR_PMT_HV, ADDR_BST_VCC_EN, ADDR_PMT_TEST_EN,
        ADDR_DEFECT_EN, ADDR_PRE_ACC_CURR, ADDR_ACTU_ACC_CURR, ADDR_ACTU_ACC_CACHE,
        ADDR_PARTICLE_BYPASS, ADDR_FIRST_TRACK, ADDR_RECOVER_FACTOR, ADDR_CALI_MODE,
        ADDR_CALI_LOW, ADDR_CALI_HIGH, ADDR_AOM_DELAY, ADDR_AOM_HOLD,
        ADDR_VERSION_0, ADDR_VERSION_1, ADDR_VERSION_2, ADDR_VERSION_3, ADDR_VERSION_4,
        ADDR_ACC_TRIG_NUM, ADDR_DBG_ACC_FLAG, ADDR_PRE_WIDEN_CNT, ADDR_CURR_WIDEN_CNT,
        ADDR_CACHE_WIDEN_CNT
    };

    addr_t hole_addrs [6] = '{16'h0000, 16'h0010, 16'h000D, 16'h007C, 16'h1014, 16'hFFFC};

    spi_reg_map dut (
        .*,
        .acc_trigger_num_i  (cnt[0]),
        .dbg_acc_flag_cnt_i (cnt[1]),
        .pre_widen_cnt_i    (cnt[2]),
        .curr_widen_cnt_i   (cnt[3]),
        .cache_widen_cnt_i  (cnt[4])
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    //////////////////////////////
    // helpers

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    // inputs change 10 ns after the edge, counters move every cycle
    task automatic next_cycle();
        @(posedge clk_i);
        #10;
        for (int i = 0; i < 5; i++) begin
            cnt[i] = $urandom;
        end
    endtask

    task automatic check_field(input string name, input data_t got, input addr_t a);
        check_value(name, got, expected_read(a));
    endtask

    // every bank output against the stored word
    task automatic check_outputs();
        check_field("first_reg_o", first_reg_o, ADDR_FIRST_REG);
        check_value("adc_offset_o", data_t'(adc_offset_o),
                    expected_read(ADDR_ADC_OFFSET) & 32'h0000_FFFF);
        check_value("dac_data_o", data_t'(dac_data_o),
                    expected_read(ADDR_PMT_HV) & 32'h0000_0FFF);
        check_field("bst_vcc_en_o", data_t'(bst_vcc_en_o), ADDR_BST_VCC_EN);
        check_field("pmt_test_en_o", data_t'(pmt_test_en_o), ADDR_PMT_TEST_EN);
        check_field("acc_defect_en_o", data_t'(acc_defect_en_o), ADDR_DEFECT_EN);
        check_field("pre_acc_curr_thre_o", data_t'(pre_acc_curr_thre_o), ADDR_PRE_ACC_CURR);
        check_field("actu_acc_curr_thre_o", data_t'(actu_acc_curr_thre_o),
                    ADDR_ACTU_ACC_CURR);
        check_field("actu_acc_cache_thre_o", data_t'(actu_acc_cache_thre_o),
                    ADDR_ACTU_ACC_CACHE);
        check_field("particle_acc_bypass_o", data_t'(particle_acc_bypass_o),
                    ADDR_PARTICLE_BYPASS);
        check_field("first_track_ctrl_o", data_t'(first_track_ctrl_o), ADDR_FIRST_TRACK);
        check_field("lp_recover_factor_o", data_t'(lp_recover_factor_o), ADDR_RECOVER_FACTOR);
        check_field("acc_cali_mode_o", data_t'(acc_cali_mode_o), ADDR_CALI_MODE);
        check_field("acc_cali_low_o", acc_cali_low_o, ADDR_CALI_LOW);
        check_field("acc_cali_high_o", acc_cali_high_o, ADDR_CALI_HIGH);
        check_field("aom_ctrl_delay_o", data_t'(aom_ctrl_delay_o), ADDR_AOM_DELAY);
        check_field("aom_ctrl_hold_o", data_t'(aom_ctrl_hold_o), ADDR_AOM_HOLD);
    endtask

    // one bus cycle then one idle cycle
    // a read in the same cycle as a write sees the old word
    task automatic access(input logic do_wr, input logic do_rd, input addr_t a,
                          input data_t d);
        data_t exp;
        int    waited;
        wr_en_i   = do_wr;
        rd_en_i   = do_rd;
        addr_i    = a;
        wr_data_i = d;
        exp = expected_read(a);
        if (do_wr) begin
            apply_write(a, d);
        end
        next_cycle();
        wr_en_i = 1'b0;
        rd_en_i = 1'b0;
        check_value("adc_offset_en_o", data_t'(adc_offset_en_o),
                    data_t'(do_wr && a == ADDR_ADC_OFFSET));
        check_value("dac_config_en_o", data_t'(dac_config_en_o),
                    data_t'(do_wr && a == ADDR_PMT_HV));
        check_outputs();
        if (do_rd) begin
            waited = 1;
            while (rd_vld_o !== 1'b1 && waited < 20) begin
                next_cycle();
                waited++;
            end
            if (rd_vld_o !== 1'b1) begin
                fail_run($sformatf("read valid never came for address %h", a));
            end
            check_value("rd_vld_o latency", data_t'(waited), 32'd1);
            check_value("rd_data_o", rd_data_o, exp);
        end else begin
            check_value("rd_vld_o", data_t'(rd_vld_o), '0);
        end

        // pulses and valid drop after one cycle, read data holds
        next_cycle();
        check_value("adc_offset_en_o", data_t'(adc_offset_en_o), '0);
        check_value("dac_config_en_o", data_t'(dac_config_en_o), '0);
        check_value("rd_vld_o", data_t'(rd_vld_o), '0);
        if (do_rd) begin
            check_value("rd_data_o", rd_data_o, exp);
        end
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        addr_t a;
        int    kind;
        void'($urandom(80691));
        clear_model();
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        wr_en_i   = 1'b0;
        rd_en_i   = 1'b0;
        addr_i    = '0;
        wr_data_i = '0;
        for (int i = 0; i < 5; i++) begin
            cnt[i] = '0;
        end

        repeat (16) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        next_cycle();

        // idle after reset
        check_value("rd_vld_o", data_t'(rd_vld_o), '0);
        check_value("adc_offset_en_o", data_t'(adc_offset_en_o), '0);
        check_value("dac_config_en_o", data_t'(dac_config_en_o), '0);
        check_outputs();

        // reset values, version string and counters
        foreach (map_addrs[i]) begin
            access(1'b0, 1'b1, map_addrs[i], '0);
        end
        foreach (hole_addrs[i]) begin
            access(1'b0, 1'b1, hole_addrs[i], '0);
        end

        // random mix of writes, reads and both together
        for (int n = 0; n < 2000; n++) begin
            if ($urandom_range(0, 9) == 0) begin
                a = addr_t'($urandom);
            end else begin
                a = map_addrs[$urandom_range(0, 26)];
            end
            kind = $urandom_range(0, 9);
            access(kind < 4, kind >= 3, a, $urandom);
        end

        // unmapped words once more after the traffic
        foreach (hole_addrs[i]) begin
            access(1'b1, 1'b0, hole_addrs[i], $urandom);
            access(1'b0, 1'b1, hole_addrs[i], '0);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
src/reg_map_pkg.sv
src/spi_reg_ctrl.sv
src/analog_ctrl_regs.sv
src/defect_thre_regs.sv
src/acc_cali_regs.sv
src/spi_reg_map.sv
tests/tb_spi_reg_map.sv
